//--- flist.f
logic/cpu_pkg.sv
logic/apb_issue.sv
logic/ctrl_fsm.sv
logic/alu_exec.sv
logic/stack_wb.sv
logic/core_top.sv
tb/tb_core.sv

//--- Makefile
# Verilator build and run for the APB register machine

VERILATOR ?= verilator
TOP ?= tb_core
RTL_TOP ?= core_top
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "simulation FAILED"; exit 1; }
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_core;

	typedef logic [cpu_pkg::DATA_W-1:0] word_t;

	localparam int CLK_HALF = 10;
	localparam int N_LOAD = cpu_pkg::REG_N;
	localparam int N_RANDOM = 200;
	// setc..reti words of the directed tests
	localparam int N_DIRECTED = 23;
	localparam int TIMEOUT_CYCLES = 40 * (N_LOAD + N_RANDOM + N_DIRECTED) + 200;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [cpu_pkg::ADDR_W-1:0] paddr;
	word_t pwdata;
	word_t prdata;
	logic pready;
	logic irq;
	word_t in_data;
	word_t out_data;

	// reference state
	word_t m_regs [cpu_pkg::REG_N];
	cpu_pkg::flags_t m_flags;
	word_t m_pc;
	word_t m_out;
	word_t m_stack [$];

	int cycles;
	int errors;
	int n_issued;

	core_top dut0 (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready),
		.irq(irq), .in_data(in_data), .out_data(out_data)
	);

	always #CLK_HALF clk = ~clk;

	task automatic stop_run(input string why);
		errors++;
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run stopped at first error");
	endtask

	// watchdog
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT_CYCLES)
			stop_run($sformatf("timeout: no end of test after %0d cycles", cycles));
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			stop_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_flags(input string name, input cpu_pkg::flags_t got,
		input cpu_pkg::flags_t exp);
		if (got !== exp)
			stop_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
	endtask

	function automatic word_t make_reg_word(input cpu_pkg::opcode_e op, input int d,
		input int s);
		return {op, 3'(d), 3'(s), 5'b00000};
	endfunction

	function automatic word_t make_imm_word(input cpu_pkg::opcode_e op, input int d,
		input int imm);
		return {op, 3'(d), 8'(imm)};
	endfunction

	// applies one instruction word to the reference state
	function automatic void model_step(input word_t word, input word_t in_val);
		logic [4:0] op;
		logic [2:0] d;
		logic [2:0] s;
		logic [7:0] imm;
		word_t a;
		word_t b;
		word_t r;
		word_t next_pc;
		word_t f;
		logic [31:0] wide;
		logic c;
		logic is_alu;
		op = word[15:11];
		d = word[10:8];
		s = word[7:5];
		imm = word[7:0];
		a = m_regs[d];
		b = m_regs[s];
		r = a;
		c = m_flags.carry;
		is_alu = 1'b0;
		next_pc = m_pc + 16'd1;
		case (op)
			cpu_pkg::OP_NOT: begin r = ~a; is_alu = 1'b1; end
			cpu_pkg::OP_INC: begin {c, r} = {1'b0, a} + 17'd1; is_alu = 1'b1; end
			// borrow out lands in carry
			cpu_pkg::OP_DEC: begin {c, r} = {1'b0, a} - 17'd1; is_alu = 1'b1; end
			cpu_pkg::OP_ADD: begin {c, r} = {1'b0, a} + {1'b0, b}; is_alu = 1'b1; end
			cpu_pkg::OP_SUB: begin {c, r} = {1'b0, a} - {1'b0, b}; is_alu = 1'b1; end
			cpu_pkg::OP_AND: begin r = a & b; is_alu = 1'b1; end
			cpu_pkg::OP_OR: begin r = a | b; is_alu = 1'b1; end
			cpu_pkg::OP_SHL:
			begin
				// bit 16 of the wide word is the last one shifted out
				wide = {16'h0000, a} << imm;
				r = wide[15:0];
				c = wide[16];
				is_alu = 1'b1;
			end
			cpu_pkg::OP_SHR:
			begin
				wide = {15'h0000, a, 1'b0} >> imm;
				r = wide[16:1];
				c = wide[0];
				is_alu = 1'b1;
			end
			cpu_pkg::OP_SETC: m_flags.carry = 1'b1;
			cpu_pkg::OP_CLRC: m_flags.carry = 1'b0;
			cpu_pkg::OP_OUT: m_out = a;
			cpu_pkg::OP_IN: m_regs[d] = in_val;
			cpu_pkg::OP_PUSH: m_stack.push_back(a);
			cpu_pkg::OP_POP: m_regs[d] = m_stack.pop_back();
			cpu_pkg::OP_MOV: m_regs[d] = b;
			cpu_pkg::OP_CALL:
			begin
				m_stack.push_back(next_pc);
				next_pc = a;
			end
			cpu_pkg::OP_RET: next_pc = m_stack.pop_back();
			cpu_pkg::OP_RETI:
			begin
				// flags on top, pc below
				f = m_stack.pop_back();
				m_flags = cpu_pkg::flags_t'(f[2:0]);
				next_pc = m_stack.pop_back();
			end
			default: ;
		endcase
		if (is_alu)
		begin
			m_regs[d] = r;
			m_flags.zero = (r == 16'h0000);
			m_flags.negative = r[15];
			m_flags.carry = c;
		end
		m_pc = next_pc;
	endfunction

	// irq entry saves the current pc, then the flags
	function automatic void model_irq_entry();
		m_stack.push_back(m_pc);
		m_stack.push_back({13'h0000, m_flags});
	endfunction

	// starts and ends 2 ns after a rising edge
	task automatic apb_write(input logic [cpu_pkg::ADDR_W-1:0] addr, input word_t data,
		output int stalls);
		stalls = 0;
		psel = 1'b1;
		pwrite = 1'b1;
		penable = 1'b0;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#2;
		penable = 1'b1;
		// sample mid cycle, well away from the edge
		@(negedge clk);
		while (!pready)
		begin
			stalls++;
			@(negedge clk);
		end
		@(posedge clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [cpu_pkg::ADDR_W-1:0] addr, output word_t data);
		psel = 1'b1;
		pwrite = 1'b0;
		penable = 1'b0;
		paddr = addr;
		@(posedge clk);
		#2;
		penable = 1'b1;
		@(negedge clk);
		if (!pready)
			stop_run("read access phase was stalled");
		data = prdata;
		@(posedge clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic issue(input word_t word);
		int stalls;
		apb_write(cpu_pkg::ADDR_INSTR, word, stalls);
		if (stalls != 0)
			stop_run("instruction write stalled with no sequence running");
		model_step(word, in_data);
		n_issued++;
	endtask

	// irq and the write setup phase start together
	task automatic issue_during_irq(input word_t word, output int stalls);
		irq = 1'b1;
		fork
			begin
				@(posedge clk);
				#2;
				irq = 1'b0;
			end
			apb_write(cpu_pkg::ADDR_INSTR, word, stalls);
		join
		model_irq_entry();
		model_step(word, in_data);
		n_issued++;
	endtask

	// read everything back and compare with the model
	task automatic compare_state();
		word_t v;
		int n;
		for (n = 0; n < cpu_pkg::REG_N; n++)
		begin
			apb_read(cpu_pkg::ADDR_REG0 + 8'(4 * n), v);
			check_word($sformatf("r%0d", n), v, m_regs[n]);
		end
		apb_read(cpu_pkg::ADDR_FLAGS, v);
		check_flags("flags", cpu_pkg::flags_t'(v[2:0]), m_flags);
		apb_read(cpu_pkg::ADDR_PC, v);
		check_word("pc", v, m_pc);
		apb_read(cpu_pkg::ADDR_OUT, v);
		check_word("out view", v, m_out);
		check_word("out_data", out_data, m_out);
	endtask

	initial
	begin
		cpu_pkg::opcode_e alu_ops [9];
		word_t w;
		word_t saved_pc;
		word_t v;
		int i;
		int stalls;
		int pick;
		alu_ops = '{cpu_pkg::OP_NOT, cpu_pkg::OP_INC, cpu_pkg::OP_DEC, cpu_pkg::OP_ADD,
			cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR, cpu_pkg::OP_SHL, cpu_pkg::OP_SHR};
		void'($urandom(7));
		cycles = 0;
		errors = 0;
		n_issued = 0;
		clk = 1'b0;
		reset = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		irq = 1'b0;
		in_data = '0;
		for (i = 0; i < cpu_pkg::REG_N; i++)
			m_regs[i] = '0;
		m_flags = '0;
		m_pc = '0;
		m_out = '0;
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b1;
		if (!pready)
			stop_run("pready low after reset");
		compare_state();

		// load every register, then random alu and shift work
		for (i = 0; i < N_LOAD; i++)
		begin
			in_data = word_t'($urandom);
			issue(make_reg_word(cpu_pkg::OP_IN, i, 0));
		end
		compare_state();
		for (i = 0; i < N_RANDOM; i++)
		begin
			pick = int'($urandom_range(0, 8));
			if (pick >= 7)
				w = make_imm_word(alu_ops[pick], int'($urandom_range(0, 7)),
					int'($urandom_range(0, 17)));
			else
				w = make_reg_word(alu_ops[pick], int'($urandom_range(0, 7)),
					int'($urandom_range(0, 7)));
			issue(w);
			compare_state();
		end

		// carry only, move, and two kinds of nop
		issue(make_reg_word(cpu_pkg::OP_SETC, 0, 0));
		compare_state();
		issue(make_reg_word(cpu_pkg::OP_CLRC, 0, 0));
		compare_state();
		issue(make_reg_word(cpu_pkg::OP_MOV, 1, 2));
		compare_state();
		issue(make_reg_word(cpu_pkg::OP_NOP, 5, 6));
		compare_state();
		// unused code
		issue({5'b11111, 11'h7ff});
		compare_state();

		// out port and input capture
		issue(make_reg_word(cpu_pkg::OP_OUT, 3, 0));
		check_word("out_data after OUT r3", out_data, m_regs[3]);
		in_data = 16'hbeef;
		issue(make_reg_word(cpu_pkg::OP_IN, 7, 0));
		compare_state();
		issue(make_reg_word(cpu_pkg::OP_OUT, 7, 0));
		check_word("out_data after OUT r7", out_data, 16'hbeef);
		compare_state();

		// lifo order, then call and return
		issue(make_reg_word(cpu_pkg::OP_PUSH, 1, 0));
		issue(make_reg_word(cpu_pkg::OP_PUSH, 2, 0));
		issue(make_reg_word(cpu_pkg::OP_POP, 4, 0));
		issue(make_reg_word(cpu_pkg::OP_POP, 5, 0));
		compare_state();
		// last word pushed comes off first
		apb_read(cpu_pkg::ADDR_REG0 + 8'(4 * 4), v);
		check_word("r4 after POP", v, m_regs[2]);
		apb_read(cpu_pkg::ADDR_REG0 + 8'(4 * 5), v);
		check_word("r5 after POP", v, m_regs[1]);
		saved_pc = m_pc;
		w = m_regs[6];
		issue(make_reg_word(cpu_pkg::OP_CALL, 6, 0));
		apb_read(cpu_pkg::ADDR_PC, v);
		check_word("pc after CALL", v, w);
		compare_state();
		issue(make_reg_word(cpu_pkg::OP_RET, 0, 0));
		apb_read(cpu_pkg::ADDR_PC, v);
		check_word("pc after RET", v, saved_pc + 16'd1);
		compare_state();

		// interrupt entry with a write held behind it
		issue(make_reg_word(cpu_pkg::OP_SETC, 0, 0));
		saved_pc = m_pc;
		issue_during_irq(make_reg_word(cpu_pkg::OP_INC, 3, 0), stalls);
		if (stalls != 2)
			stop_run($sformatf("write behind irq stalled %0d cycles instead of 2", stalls));
		compare_state();
		// peek at the frame, then put it back
		issue(make_reg_word(cpu_pkg::OP_POP, 1, 0));
		issue(make_reg_word(cpu_pkg::OP_POP, 2, 0));
		compare_state();
		apb_read(cpu_pkg::ADDR_REG0 + 8'(4 * 2), v);
		check_word("stacked pc", v, saved_pc);
		issue(make_reg_word(cpu_pkg::OP_PUSH, 2, 0));
		issue(make_reg_word(cpu_pkg::OP_PUSH, 1, 0));
		issue(make_reg_word(cpu_pkg::OP_CLRC, 0, 0));
		issue(make_reg_word(cpu_pkg::OP_NOT, 0, 0));
		compare_state();
		issue(make_reg_word(cpu_pkg::OP_RETI, 0, 0));
		compare_state();
		apb_read(cpu_pkg::ADDR_PC, v);
		check_word("pc after RETI", v, saved_pc);

		$display("%0d instructions issued in %0d cycles", n_issued, cycles);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top (
	input wire logic clk,
	input wire logic reset,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [cpu_pkg::ADDR_W-1:0] paddr,
	input wire logic [cpu_pkg::DATA_W-1:0] pwdata,
	output logic [cpu_pkg::DATA_W-1:0] prdata,
	output logic pready,
	input wire logic irq,
	input wire logic [cpu_pkg::DATA_W-1:0] in_data,
	output logic [cpu_pkg::DATA_W-1:0] out_data
);

	logic busy;
	cpu_pkg::instr_u instr;
	logic instr_valid;
	cpu_pkg::ctrl_t ctrl;
	cpu_pkg::exec_res_t res;
	logic wb_en;
	logic [cpu_pkg::REG_IDX_W-1:0] wb_rdst;
	logic [cpu_pkg::DATA_W-1:0] wb_data;
	logic [cpu_pkg::DATA_W-1:0] pop_data;
	cpu_pkg::regs_t regs_view;
	cpu_pkg::flags_t flags_view;
	logic [cpu_pkg::DATA_W-1:0] pc_view;

	// host port
	apb_issue u_apb (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready),
		.busy(busy), .instr(instr), .instr_valid(instr_valid),
		.regs_view(regs_view), .flags_view(flags_view), .pc_view(pc_view),
		.out_view(out_data)
	);

	// decode and sequences
	ctrl_fsm u_ctrl (
		.clk(clk), .reset(reset),
		.instr(instr), .instr_valid(instr_valid), .irq(irq),
		.busy(busy), .ctrl(ctrl)
	);

	alu_exec u_exec (
		.clk(clk), .reset(reset),
		.ctrl(ctrl),
		.wb_en(wb_en), .wb_rdst(wb_rdst), .wb_data(wb_data), .pop_data(pop_data),
		.res(res),
		.regs_view(regs_view), .flags_view(flags_view), .pc_view(pc_view)
	);

	stack_wb u_wb (
		.clk(clk), .reset(reset),
		.res(res), .in_data(in_data),
		.wb_en(wb_en), .wb_rdst(wb_rdst), .wb_data(wb_data),
		.pop_data(pop_data), .out_data(out_data)
	);

endmodule

`default_nettype wire

//--- logic/stack_wb.sv
`timescale 1ns/10ps
`default_nettype none

module stack_wb (
	input wire logic clk,
	input wire logic reset,
	input wire cpu_pkg::exec_res_t res,
	input wire logic [cpu_pkg::DATA_W-1:0] in_data,
	output logic wb_en,
	output logic [cpu_pkg::REG_IDX_W-1:0] wb_rdst,
	output logic [cpu_pkg::DATA_W-1:0] wb_data,
	output logic [cpu_pkg::DATA_W-1:0] pop_data,
	output logic [cpu_pkg::DATA_W-1:0] out_data
);

	logic [cpu_pkg::DATA_W-1:0] mem [cpu_pkg::STACK_DEPTH];
	// 0 is empty, counts down on push
	logic [cpu_pkg::SP_W-1:0] sp;
	logic [cpu_pkg::SP_W-1:0] sp_dec;
	logic [cpu_pkg::DATA_W-1:0] push_value;

	assign sp_dec = sp - 1'b1;

	// top of stack
	assign pop_data = mem[sp[cpu_pkg::SP_W-2:0]];

	// what goes on the stack
	always_comb
	begin
		push_value = res.alu_value;
		case (res.push_src)
			cpu_pkg::SRC_PC: push_value = res.pc_value;
			cpu_pkg::SRC_FLAGS:
			begin
				push_value = '0;
				push_value[$bits(cpu_pkg::flags_t)-1:0] = res.flags;
			end
			default: push_value = res.alu_value;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (res.push)
			mem[sp_dec[cpu_pkg::SP_W-2:0]] <= push_value;
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			sp <= '0;
		else if (res.push)
			sp <= sp_dec;
		else if (res.pop)
			sp <= sp + 1'b1;
	end

	// write-back source
	always_comb
	begin
		case (res.wb_sel)
			cpu_pkg::WB_SRC: wb_data = res.src_value;
			cpu_pkg::WB_IN: wb_data = in_data;
			cpu_pkg::WB_STACK: wb_data = pop_data;
			default: wb_data = res.alu_value;
		endcase
	end

	assign wb_en = res.reg_write;
	assign wb_rdst = res.rdst;

	// out port holds Rdst from the last OUT
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			out_data <= '0;
		else if (res.out_en)
			out_data <= res.alu_value;
	end

	// program order must keep the stack in range
	a_no_overflow: assert property (@(posedge clk) disable iff (!reset)
		res.push |-> (sp != cpu_pkg::SP_FULL))
		else $error("stack overflow");

	a_no_underflow: assert property (@(posedge clk) disable iff (!reset)
		res.pop |-> (sp != '0))
		else $error("stack underflow");

endmodule

`default_nettype wire

//--- logic/alu_exec.sv
`timescale 1ns/10ps
`default_nettype none

module alu_exec (
	input wire logic clk,
	input wire logic reset,
	input wire cpu_pkg::ctrl_t ctrl,
	input wire logic wb_en,
	input wire logic [cpu_pkg::REG_IDX_W-1:0] wb_rdst,
	input wire logic [cpu_pkg::DATA_W-1:0] wb_data,
	input wire logic [cpu_pkg::DATA_W-1:0] pop_data,
	output cpu_pkg::exec_res_t res,
	output cpu_pkg::regs_t regs_view,
	output cpu_pkg::flags_t flags_view,
	output logic [cpu_pkg::DATA_W-1:0] pc_view
);

	cpu_pkg::regs_t regs;
	cpu_pkg::flags_t flags;
	cpu_pkg::flags_t flags_next;
	logic [cpu_pkg::DATA_W-1:0] pc;
	logic [cpu_pkg::DATA_W-1:0] op_a;
	logic [cpu_pkg::DATA_W-1:0] op_src;
	logic [cpu_pkg::DATA_W-1:0] op_b;
	logic [cpu_pkg::DATA_W-1:0] alu_r;
	logic alu_c;
	logic pc_step;

	// operands
	assign op_a = regs[ctrl.rdst];
	assign op_src = regs[ctrl.rsrc];
	assign op_b = ctrl.use_imm ? {{(cpu_pkg::DATA_W-8){1'b0}}, ctrl.imm8} : op_src;

	// alu, carry is the 17th bit
	always_comb
	begin
		alu_c = 1'b0;
		alu_r = op_a;
		case (ctrl.alu_op)
			cpu_pkg::ALU_NOT: alu_r = ~op_a;
			cpu_pkg::ALU_INC: {alu_c, alu_r} = {1'b0, op_a} + {{cpu_pkg::DATA_W{1'b0}}, 1'b1};
			// borrow out of the top
			cpu_pkg::ALU_DEC: {alu_c, alu_r} = {1'b0, op_a} - {{cpu_pkg::DATA_W{1'b0}}, 1'b1};
			cpu_pkg::ALU_ADD: {alu_c, alu_r} = {1'b0, op_a} + {1'b0, op_b};
			cpu_pkg::ALU_SUB: {alu_c, alu_r} = {1'b0, op_a} - {1'b0, op_b};
			cpu_pkg::ALU_AND: alu_r = op_a & op_b;
			cpu_pkg::ALU_OR: alu_r = op_a | op_b;
			// last bit shifted out lands in carry
			cpu_pkg::ALU_SHL: {alu_c, alu_r} = {1'b0, op_a} << op_b;
			cpu_pkg::ALU_SHR: {alu_r, alu_c} = {op_a, 1'b0} >> op_b;
			default: alu_r = op_a;
		endcase
	end

	// flag update
	always_comb
	begin
		flags_next = flags;
		if (ctrl.flags_load_stack)
			flags_next = cpu_pkg::flags_t'(pop_data[$bits(cpu_pkg::flags_t)-1:0]);
		else if (ctrl.flag_write)
		begin
			// setc and clrc touch only carry
			if (ctrl.alu_op != cpu_pkg::ALU_PASS)
			begin
				flags_next.zero = (alu_r == '0);
				flags_next.negative = alu_r[cpu_pkg::DATA_W-1];
			end
			case (ctrl.carry_sel)
				cpu_pkg::CARRY_SET: flags_next.carry = 1'b1;
				cpu_pkg::CARRY_CLR: flags_next.carry = 1'b0;
				cpu_pkg::CARRY_ALU: flags_next.carry = alu_c;
				default: flags_next.carry = flags.carry;
			endcase
		end
	end

	// sequence steps and jumps leave the counter alone
	assign pc_step = ctrl.valid && !ctrl.pc_load_reg && !ctrl.pc_load_stack
		&& !ctrl.flags_load_stack && !(ctrl.push && (ctrl.push_src != cpu_pkg::SRC_REG));

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			regs <= '0;
			flags <= '0;
			pc <= '0;
		end
		else
		begin
			if (wb_en)
				regs[wb_rdst] <= wb_data;
			flags <= flags_next;
			if (ctrl.pc_load_reg)
				pc <= op_a;
			else if (ctrl.pc_load_stack)
				pc <= pop_data;
			else if (pc_step)
				pc <= pc + 1'b1;
		end
	end

	// to the result stage, same cycle
	always_comb
	begin
		res.alu_value = alu_r;
		res.src_value = op_src;
		// call saves the address after itself, irq the current one
		res.pc_value = ctrl.pc_load_reg ? pc + 1'b1 : pc;
		res.flags = flags;
		res.rdst = ctrl.rdst;
		res.reg_write = ctrl.reg_write;
		res.wb_sel = ctrl.wb_sel;
		res.push = ctrl.push;
		res.pop = ctrl.pop;
		res.push_src = ctrl.push_src;
		res.out_en = ctrl.out_en;
	end

	assign regs_view = regs;
	assign flags_view = flags;
	assign pc_view = pc;

endmodule

`default_nettype wire

//--- logic/ctrl_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_fsm (
	input wire logic clk,
	input wire logic reset,
	input wire cpu_pkg::instr_u instr,
	input wire logic instr_valid,
	input wire logic irq,
	output logic busy,
	output cpu_pkg::ctrl_t ctrl
);

	typedef enum logic [1:0] {IDLE, PUSH_PC, PUSH_FLAGS, POP_PC} state_e;

	state_e state;
	cpu_pkg::opcode_e op;

	assign op = instr.r.opcode;
	assign busy = (state != IDLE);

	// control bundle
	always_comb
	begin
		// defaults, nothing happens
		ctrl = '0;
		ctrl.alu_op = cpu_pkg::ALU_PASS;
		ctrl.wb_sel = cpu_pkg::WB_ALU;
		ctrl.carry_sel = cpu_pkg::CARRY_KEEP;
		ctrl.push_src = cpu_pkg::SRC_REG;
		case (state)
			IDLE:
			begin
				if (instr_valid)
				begin
					ctrl.valid = 1'b1;
					ctrl.rdst = instr.r.rdst;
					ctrl.rsrc = instr.r.rsrc;
					case (op[4:3])
						// alu group, rsrc from the register view
						2'b00:
						begin
							case (op)
								cpu_pkg::OP_NOT: ctrl.alu_op = cpu_pkg::ALU_NOT;
								cpu_pkg::OP_INC: ctrl.alu_op = cpu_pkg::ALU_INC;
								cpu_pkg::OP_DEC: ctrl.alu_op = cpu_pkg::ALU_DEC;
								cpu_pkg::OP_ADD: ctrl.alu_op = cpu_pkg::ALU_ADD;
								cpu_pkg::OP_SUB: ctrl.alu_op = cpu_pkg::ALU_SUB;
								cpu_pkg::OP_AND: ctrl.alu_op = cpu_pkg::ALU_AND;
								cpu_pkg::OP_OR: ctrl.alu_op = cpu_pkg::ALU_OR;
								default: ctrl.alu_op = cpu_pkg::ALU_PASS;
							endcase
							// unknown code stays a nop
							if (ctrl.alu_op != cpu_pkg::ALU_PASS)
							begin
								ctrl.reg_write = 1'b1;
								ctrl.flag_write = 1'b1;
							end
							// logic ops leave carry alone
							if (ctrl.alu_op inside {cpu_pkg::ALU_INC, cpu_pkg::ALU_DEC,
								cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB})
								ctrl.carry_sel = cpu_pkg::CARRY_ALU;
						end
						// one operand group
						2'b01:
						begin
							case (op)
								cpu_pkg::OP_SETC:
								begin
									ctrl.flag_write = 1'b1;
									ctrl.carry_sel = cpu_pkg::CARRY_SET;
								end
								cpu_pkg::OP_CLRC:
								begin
									ctrl.flag_write = 1'b1;
									ctrl.carry_sel = cpu_pkg::CARRY_CLR;
								end
								// alu passes Rdst through
								cpu_pkg::OP_OUT: ctrl.out_en = 1'b1;
								cpu_pkg::OP_IN:
								begin
									ctrl.reg_write = 1'b1;
									ctrl.wb_sel = cpu_pkg::WB_IN;
								end
								cpu_pkg::OP_PUSH: ctrl.push = 1'b1;
								cpu_pkg::OP_POP:
								begin
									ctrl.pop = 1'b1;
									ctrl.reg_write = 1'b1;
									ctrl.wb_sel = cpu_pkg::WB_STACK;
								end
								default: ;
							endcase
						end
						// two operand group, shifts use the imm view
						2'b10:
						begin
							case (op)
								cpu_pkg::OP_MOV:
								begin
									ctrl.reg_write = 1'b1;
									ctrl.wb_sel = cpu_pkg::WB_SRC;
								end
								cpu_pkg::OP_SHL, cpu_pkg::OP_SHR:
								begin
									ctrl.alu_op = (op == cpu_pkg::OP_SHL) ? cpu_pkg::ALU_SHL
										: cpu_pkg::ALU_SHR;
									ctrl.use_imm = 1'b1;
									ctrl.imm8 = instr.i.imm8;
									ctrl.reg_write = 1'b1;
									ctrl.flag_write = 1'b1;
									ctrl.carry_sel = cpu_pkg::CARRY_ALU;
								end
								default: ;
							endcase
						end
						// call and returns
						default:
						begin
							case (op)
								// push return address, jump to Rdst
								cpu_pkg::OP_CALL:
								begin
									ctrl.push = 1'b1;
									ctrl.push_src = cpu_pkg::SRC_PC;
									ctrl.pc_load_reg = 1'b1;
								end
								cpu_pkg::OP_RET:
								begin
									ctrl.pop = 1'b1;
									ctrl.pc_load_stack = 1'b1;
								end
								// flags first, pc in POP_PC
								cpu_pkg::OP_RETI:
								begin
									ctrl.pop = 1'b1;
									ctrl.flags_load_stack = 1'b1;
								end
								default: ;
							endcase
						end
					endcase
				end
			end
			PUSH_PC:
			begin
				ctrl.valid = 1'b1;
				ctrl.push = 1'b1;
				ctrl.push_src = cpu_pkg::SRC_PC;
			end
			PUSH_FLAGS:
			begin
				ctrl.valid = 1'b1;
				ctrl.push = 1'b1;
				ctrl.push_src = cpu_pkg::SRC_FLAGS;
			end
			POP_PC:
			begin
				ctrl.valid = 1'b1;
				ctrl.pop = 1'b1;
				ctrl.pc_load_stack = 1'b1;
			end
			default: ;
		endcase
	end

	// sequence state
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE:
				begin
					// an accepted word wins over irq
					if (instr_valid && (op == cpu_pkg::OP_RETI))
						state <= POP_PC;
					else if (!instr_valid && irq)
						state <= PUSH_PC;
				end
				PUSH_PC: state <= PUSH_FLAGS;
				default: state <= IDLE;
			endcase
		end
	end

	// issue side must honour busy
	a_no_issue_when_busy: assert property (@(posedge clk) disable iff (!reset)
		busy |-> !instr_valid)
		else $error("instruction issued during a stack sequence");

endmodule

`default_nettype wire

//--- logic/apb_issue.sv
`timescale 1ns/10ps
`default_nettype none

module apb_issue (
	input wire logic clk,
	input wire logic reset,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [cpu_pkg::ADDR_W-1:0] paddr,
	input wire logic [cpu_pkg::DATA_W-1:0] pwdata,
	output logic [cpu_pkg::DATA_W-1:0] prdata,
	output logic pready,
	input wire logic busy,
	output cpu_pkg::instr_u instr,
	output logic instr_valid,
	input wire cpu_pkg::regs_t regs_view,
	input wire cpu_pkg::flags_t flags_view,
	input wire logic [cpu_pkg::DATA_W-1:0] pc_view,
	input wire logic [cpu_pkg::DATA_W-1:0] out_view
);

	logic instr_wr;
	logic reg_hit;

	// access phase of a write to the instruction port
	assign instr_wr = psel && penable && pwrite && (paddr == cpu_pkg::ADDR_INSTR);

	// hold the host off while a sequence runs
	assign pready = !(instr_wr && busy);
	assign instr_valid = instr_wr && !busy;
	assign instr = cpu_pkg::instr_u'(pwdata);

	// register window, word aligned
	assign reg_hit = (paddr >= cpu_pkg::ADDR_REG0) && (paddr < cpu_pkg::ADDR_REG_END)
		&& (paddr[1:0] == 2'b00);

	// read mux, no wait states
	always_comb
	begin
		prdata = '0;
		if (reg_hit)
			// base is 32-aligned so bits 4:2 are the index
			prdata = regs_view[paddr[2 +: cpu_pkg::REG_IDX_W]];
		else
		begin
			case (paddr)
				cpu_pkg::ADDR_OUT: prdata = out_view;
				cpu_pkg::ADDR_PC: prdata = pc_view;
				cpu_pkg::ADDR_FLAGS: prdata[$bits(cpu_pkg::flags_t)-1:0] = flags_view;
				default: prdata = '0;
			endcase
		end
	end

	// host must keep its word while stalled
	a_stall_data_stable: assert property (@(posedge clk) disable iff (!reset)
		(instr_wr && !pready) |=> $stable(pwdata))
		else $error("pwdata changed during a stalled write");

endmodule

`default_nettype wire

//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// datapath sizes
	localparam int DATA_W = 16;
	localparam int REG_N = 8;
	localparam int STACK_DEPTH = 16;
	localparam int ADDR_W = 8;
	localparam int REG_IDX_W = $clog2(REG_N);
	// one extra bit so a full stack differs from an empty one
	localparam int SP_W = $clog2(STACK_DEPTH) + 1;
	localparam logic [SP_W-1:0] SP_FULL = SP_W'(STACK_DEPTH);

	// apb address map, registers at ADDR_REG0 + 4*n
	localparam logic [ADDR_W-1:0] ADDR_INSTR = 8'h00;
	localparam logic [ADDR_W-1:0] ADDR_OUT = 8'h04;
	localparam logic [ADDR_W-1:0] ADDR_PC = 8'h08;
	localparam logic [ADDR_W-1:0] ADDR_FLAGS = 8'h0C;
	localparam logic [ADDR_W-1:0] ADDR_REG0 = 8'h20;
	localparam logic [ADDR_W-1:0] ADDR_REG_END = ADDR_REG0 + 8'(4 * REG_N);

	typedef logic [REG_N-1:0][DATA_W-1:0] regs_t;

	// upper two bits pick the group
	typedef enum logic [4:0] {
		OP_NOT = 5'b00000, OP_INC = 5'b00001, OP_DEC = 5'b00010, OP_ADD = 5'b00011,
		OP_SUB = 5'b00100, OP_AND = 5'b00101, OP_OR = 5'b00110,
		OP_NOP = 5'b01000, OP_SETC = 5'b01001, OP_CLRC = 5'b01010, OP_OUT = 5'b01011,
		OP_IN = 5'b01100, OP_PUSH = 5'b01101, OP_POP = 5'b01110,
		OP_MOV = 5'b10000, OP_SHL = 5'b10100, OP_SHR = 5'b10101,
		OP_CALL = 5'b11100, OP_RET = 5'b11101, OP_RETI = 5'b11110
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_NOT = 4'd0, ALU_INC = 4'd1, ALU_DEC = 4'd2, ALU_ADD = 4'd3, ALU_SUB = 4'd4,
		ALU_AND = 4'd5, ALU_OR = 4'd6, ALU_SHL = 4'd7, ALU_SHR = 4'd8, ALU_PASS = 4'd15
	} alu_op_e;

	// two-operand register form
	typedef struct packed {
		opcode_e opcode;
		logic [REG_IDX_W-1:0] rdst;
		logic [REG_IDX_W-1:0] rsrc;
		logic [4:0] spare;
	} instr_reg_t;

	// immediate form, imm8 is the shift amount
	typedef struct packed {
		opcode_e opcode;
		logic [REG_IDX_W-1:0] rdst;
		logic [7:0] imm8;
	} instr_imm_t;

	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_u;

	typedef enum logic [1:0] {WB_ALU, WB_SRC, WB_IN, WB_STACK} wb_sel_e;
	typedef enum logic [1:0] {CARRY_KEEP, CARRY_SET, CARRY_CLR, CARRY_ALU} carry_sel_e;
	typedef enum logic [1:0] {SRC_REG, SRC_PC, SRC_FLAGS} push_src_e;

	typedef struct packed {
		logic zero;
		logic negative;
		logic carry;
	} flags_t;

	typedef struct packed {
		logic valid;
		alu_op_e alu_op;
		logic use_imm;
		logic [REG_IDX_W-1:0] rdst;
		logic [REG_IDX_W-1:0] rsrc;
		logic [7:0] imm8;
		logic reg_write;
		wb_sel_e wb_sel;
		logic flag_write;
		carry_sel_e carry_sel;
		logic push;
		logic pop;
		push_src_e push_src;
		logic out_en;
		logic pc_load_reg;
		logic pc_load_stack;
		logic flags_load_stack;
	} ctrl_t;

	// what the result stage needs from execute
	typedef struct packed {
		logic [DATA_W-1:0] alu_value;
		logic [DATA_W-1:0] src_value;
		logic [DATA_W-1:0] pc_value;
		flags_t flags;
		logic [REG_IDX_W-1:0] rdst;
		logic reg_write;
		wb_sel_e wb_sel;
		logic push;
		logic pop;
		push_src_e push_src;
		logic out_en;
	} exec_res_t;

endpackage

`default_nettype wire
